//--- design/sched_defines.svh
`ifndef SCHED_DEFINES_SVH
`define SCHED_DEFINES_SVH

// data and address widths
`define SCHED_DATA_BITS   512
`define SCHED_PADDR_BITS  19
`define SCHED_ROW_BITS    8
`define SCHED_COL_BITS    4
`define SCHED_BG_BITS     1
`define SCHED_BA_BITS     2

`define SCHED_BANKS        8  // bank groups times banks per group
`define SCHED_QUEUE_DEPTH  8

// busy times in clock cycles
`define SCHED_ACT_LATENCY  8
`define SCHED_PRE_LATENCY  5
`define SCHED_COL_GAP      4

// opcodes in the top five bits of the command address
`define SCHED_OP_READ   5'b01101
`define SCHED_OP_WRITE  5'b01100
`define SCHED_OP_ACT    5'b00000
`define SCHED_OP_PRE    5'b01010

`endif

//--- design/sched_pkg.sv
`default_nettype none

`include "sched_defines.svh"

package sched_pkg;

    localparam int OP_BITS = 5;
    localparam int BANK_IDX_BITS = `SCHED_BG_BITS + `SCHED_BA_BITS;
    localparam int ROW_PAD_BITS =
        `SCHED_PADDR_BITS - OP_BITS - BANK_IDX_BITS - `SCHED_ROW_BITS;
    localparam int COL_PAD_BITS =
        `SCHED_PADDR_BITS - OP_BITS - BANK_IDX_BITS - `SCHED_COL_BITS;

    typedef enum logic [2:0] {
        CMD_READ  = 3'd0,
        CMD_WRITE = 3'd1,
        CMD_ACT   = 3'd2,
        CMD_PRE   = 3'd3
    } sched_cmd_e;

    typedef struct packed {
        logic                        write;
        logic [`SCHED_BG_BITS-1:0]   bank_group;
        logic [`SCHED_BA_BITS-1:0]   bank;
        logic [`SCHED_ROW_BITS-1:0]  row;
        logic [`SCHED_COL_BITS-1:0]  col;
        logic [`SCHED_DATA_BITS-1:0] data;  // only meaningful for writes
    } sched_req_t;

    // activate carries the row
    typedef struct packed {
        logic [OP_BITS-1:0]         opcode;
        logic [`SCHED_BG_BITS-1:0]  bank_group;
        logic [`SCHED_BA_BITS-1:0]  bank;
        logic [ROW_PAD_BITS-1:0]    pad;
        logic [`SCHED_ROW_BITS-1:0] row;
    } row_form_t;

    // read, write and precharge carry the column
    typedef struct packed {
        logic [OP_BITS-1:0]         opcode;
        logic [`SCHED_BG_BITS-1:0]  bank_group;
        logic [`SCHED_BA_BITS-1:0]  bank;
        logic [COL_PAD_BITS-1:0]    pad;
        logic [`SCHED_COL_BITS-1:0] col;
    } col_form_t;

    typedef union packed {
        row_form_t row_form;
        col_form_t col_form;
    } cmd_addr_u;

endpackage

`default_nettype wire

//--- design/sched_if.sv
`default_nettype none

`include "sched_defines.svh"

// head of the request queue
interface req_if;
    import sched_pkg::*;

    logic       head_valid;
    sched_req_t head;
    logic       pop;  // one cycle, retires the head

    modport source (output head_valid, output head, input pop);
    modport sink (input head_valid, input head, output pop);
endinterface

// one issued command
interface cmd_if;
    import sched_pkg::*;

    logic                        issue;  // single-cycle pulse
    sched_cmd_e                  cmd;
    logic [`SCHED_BG_BITS-1:0]   bank_group;
    logic [`SCHED_BA_BITS-1:0]   bank;
    logic [`SCHED_ROW_BITS-1:0]  row;
    logic [`SCHED_COL_BITS-1:0]  col;
    logic [`SCHED_DATA_BITS-1:0] data;

    modport source (
        output issue, output cmd, output bank_group, output bank,
        output row, output col, output data
    );
    modport sink (
        input issue, input cmd, input bank_group, input bank,
        input row, input col, input data
    );
endinterface

`default_nettype wire

//--- design/request_decode.sv
`default_nettype none

`include "sched_defines.svh"

module request_decode (
    input  logic                         clk_in,
    input  logic                         rst_in,
    input  logic [`SCHED_PADDR_BITS-1:0] mem_bus_addr_in,
    input  logic                         valid_in,
    input  logic                         write_in,
    input  logic [`SCHED_DATA_BITS-1:0]  val_in,
    output logic                         queue_full,
    req_if.source                        req
);
    import sched_pkg::*;

    localparam int PTR_BITS = $clog2(`SCHED_QUEUE_DEPTH);
    localparam int BA_LSB = `SCHED_COL_BITS;
    localparam int BG_LSB = BA_LSB + `SCHED_BA_BITS;
    localparam int ROW_LSB = BG_LSB + `SCHED_BG_BITS;
    localparam logic [PTR_BITS:0] FULL_COUNT = (PTR_BITS + 1)'(`SCHED_QUEUE_DEPTH);
    localparam logic [PTR_BITS-1:0] LAST_SLOT = PTR_BITS'(`SCHED_QUEUE_DEPTH - 1);

    sched_req_t          queue_mem [`SCHED_QUEUE_DEPTH];
    sched_req_t          new_req;
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [PTR_BITS:0]   count;
    logic                push;
    logic                pop;

    // bus address layout, top bits above the row are unused
    always_comb begin
        new_req.write      = write_in;
        new_req.col        = mem_bus_addr_in[BA_LSB-1:0];
        new_req.bank       = mem_bus_addr_in[BG_LSB-1:BA_LSB];
        new_req.bank_group = mem_bus_addr_in[ROW_LSB-1:BG_LSB];
        new_req.row        = mem_bus_addr_in[ROW_LSB+`SCHED_ROW_BITS-1:ROW_LSB];
        new_req.data       = val_in;
    end

    assign queue_full = (count == FULL_COUNT);
    assign push = valid_in && !queue_full;  // offered while full is dropped
    assign pop = req.pop && req.head_valid;

    assign req.head_valid = (count != '0);
    assign req.head = queue_mem[rd_ptr];

    always_ff @(posedge clk_in) begin
        if (push) begin
            queue_mem[wr_ptr] <= new_req;
        end
    end

    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // both or neither
            endcase
        end
    end

endmodule

`default_nettype wire

//--- design/bank_tracker.sv
`default_nettype none

`include "sched_defines.svh"

module bank_tracker (
    input  logic                               clk_in,
    input  logic                               rst_in,
    input  logic                               issue,
    input  sched_pkg::sched_cmd_e              cmd,
    input  logic [sched_pkg::BANK_IDX_BITS-1:0] bank_idx,
    input  logic [`SCHED_ROW_BITS-1:0]         row,
    output logic [`SCHED_BANKS-1:0]            row_open,
    output logic [`SCHED_ROW_BITS-1:0]         open_row [`SCHED_BANKS],
    output logic [`SCHED_BANKS-1:0]            bank_ready
);
    import sched_pkg::*;

    localparam int MAX_LATENCY = (`SCHED_ACT_LATENCY > `SCHED_PRE_LATENCY) ?
                                 `SCHED_ACT_LATENCY : `SCHED_PRE_LATENCY;
    localparam int TIMER_BITS = $clog2(MAX_LATENCY + 1);
    localparam logic [TIMER_BITS-1:0] ACT_LOAD = TIMER_BITS'(`SCHED_ACT_LATENCY);
    localparam logic [TIMER_BITS-1:0] PRE_LOAD = TIMER_BITS'(`SCHED_PRE_LATENCY);

    logic [TIMER_BITS-1:0]   busy_timer [`SCHED_BANKS];
    logic [`SCHED_BANKS-1:0] bank_sel;
    logic                    do_act;
    logic                    do_pre;

    always_comb begin
        bank_sel = '0;
        bank_sel[bank_idx] = issue;  // one-hot of the addressed bank
    end

    // column commands leave the bank state alone
    assign do_act = (cmd == CMD_ACT);
    assign do_pre = (cmd == CMD_PRE);

    always_comb begin
        for (int b = 0; b < `SCHED_BANKS; b++) begin
            bank_ready[b] = (busy_timer[b] == '0);
        end
    end

    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            row_open <= '0;
            for (int b = 0; b < `SCHED_BANKS; b++) begin
                busy_timer[b] <= '0;
            end
        end else begin
            for (int b = 0; b < `SCHED_BANKS; b++) begin
                if (bank_sel[b] && do_act) begin
                    row_open[b]   <= 1'b1;
                    busy_timer[b] <= ACT_LOAD;
                end else if (bank_sel[b] && do_pre) begin
                    row_open[b]   <= 1'b0;
                    busy_timer[b] <= PRE_LOAD;
                end else if (busy_timer[b] != '0) begin
                    busy_timer[b] <= busy_timer[b] - 1'b1;  // count down to ready
                end
            end
        end
    end

    // row only matters while row_open is set
    always_ff @(posedge clk_in) begin
        for (int b = 0; b < `SCHED_BANKS; b++) begin
            if (bank_sel[b] && do_act) begin
                open_row[b] <= row;
            end
        end
    end

endmodule

`default_nettype wire

//--- design/command_arbiter.sv
`default_nettype none

`include "sched_defines.svh"

module command_arbiter (
    input  logic  clk_in,
    input  logic  rst_in,
    input  logic  cmd_ready,
    req_if.sink   req,
    cmd_if.source cmd
);
    import sched_pkg::*;

    localparam int GAP_BITS = $clog2(`SCHED_COL_GAP + 1);
    localparam logic [GAP_BITS-1:0] GAP_LOAD = GAP_BITS'(`SCHED_COL_GAP);

    logic [BANK_IDX_BITS-1:0]   head_bank;
    logic [`SCHED_BANKS-1:0]    row_open;
    logic [`SCHED_ROW_BITS-1:0] open_row [`SCHED_BANKS];
    logic [`SCHED_BANKS-1:0]    bank_ready;
    logic                       row_hit;
    logic                       is_col;
    logic                       col_ok;
    logic                       issue_now;
    sched_cmd_e                 next_cmd;
    logic [GAP_BITS-1:0]        gap_cnt;

    assign head_bank = {req.head.bank_group, req.head.bank};
    assign row_hit = row_open[head_bank] && (open_row[head_bank] == req.head.row);

    // what the head request needs next
    always_comb begin
        if (row_hit) begin
            next_cmd = req.head.write ? CMD_WRITE : CMD_READ;
        end else if (row_open[head_bank]) begin
            next_cmd = CMD_PRE;  // wrong row open
        end else begin
            next_cmd = CMD_ACT;
        end
    end

    assign is_col = row_hit;
    assign col_ok = (gap_cnt == '0);
    assign issue_now = cmd_ready && req.head_valid && bank_ready[head_bank] &&
                       (!is_col || col_ok);

    assign req.pop = issue_now && is_col;  // read or write retires the head

    assign cmd.issue      = issue_now;
    assign cmd.cmd        = next_cmd;
    assign cmd.bank_group = req.head.bank_group;
    assign cmd.bank       = req.head.bank;
    assign cmd.row        = req.head.row;
    assign cmd.col        = req.head.col;
    assign cmd.data       = req.head.data;

    // blocks column commands for COL_GAP cycles after one issues
    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            gap_cnt <= '0;
        end else if (issue_now && is_col) begin
            gap_cnt <= GAP_LOAD;
        end else if (gap_cnt != '0) begin
            gap_cnt <= gap_cnt - 1'b1;
        end
    end

    bank_tracker u_bank_tracker (
        .clk_in     (clk_in),
        .rst_in     (rst_in),
        .issue      (issue_now),
        .cmd        (next_cmd),
        .bank_idx   (head_bank),
        .row        (req.head.row),
        .row_open   (row_open),
        .open_row   (open_row),
        .bank_ready (bank_ready)
    );

endmodule

`default_nettype wire

//--- design/command_encoder.sv
`default_nettype none

`include "sched_defines.svh"

module command_encoder (
    input  logic                         clk_in,
    input  logic                         rst_in,
    cmd_if.sink                          cmd,
    output logic [`SCHED_PADDR_BITS-1:0] addr_out,
    output logic [`SCHED_BG_BITS-1:0]    bank_group_out,
    output logic [`SCHED_BA_BITS-1:0]    bank_out,
    output logic [`SCHED_ROW_BITS-1:0]   row_out,
    output logic [`SCHED_COL_BITS-1:0]   col_out,
    output logic [`SCHED_DATA_BITS-1:0]  val_out,
    output logic [2:0]                   cmd_out,
    output logic                         valid_out
);
    import sched_pkg::*;

    cmd_addr_u addr_word;

    always_comb begin
        addr_word = '0;  // keeps the pad bits zero
        if (cmd.cmd == CMD_ACT) begin
            addr_word.row_form.opcode     = `SCHED_OP_ACT;
            addr_word.row_form.bank_group = cmd.bank_group;
            addr_word.row_form.bank       = cmd.bank;
            addr_word.row_form.row        = cmd.row;
        end else begin
            case (cmd.cmd)
                CMD_READ:  addr_word.col_form.opcode = `SCHED_OP_READ;
                CMD_WRITE: addr_word.col_form.opcode = `SCHED_OP_WRITE;
                default:   addr_word.col_form.opcode = `SCHED_OP_PRE;
            endcase
            addr_word.col_form.bank_group = cmd.bank_group;
            addr_word.col_form.bank       = cmd.bank;
            addr_word.col_form.col        = cmd.col;
        end
    end

    // idle address is all ones
    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            valid_out <= 1'b0;
            addr_out  <= '1;
        end else begin
            valid_out <= cmd.issue;
            addr_out  <= cmd.issue ? addr_word : '1;
        end
    end

    always_ff @(posedge clk_in) begin
        if (cmd.issue) begin
            cmd_out        <= cmd.cmd;
            bank_group_out <= cmd.bank_group;
            bank_out       <= cmd.bank;
            row_out        <= cmd.row;
            col_out        <= cmd.col;
        end
        // data shows only with an issued write
        val_out <= (cmd.issue && cmd.cmd == CMD_WRITE) ? cmd.data : '0;
    end

endmodule

`default_nettype wire

//--- design/request_scheduler.sv
`default_nettype none

`include "sched_defines.svh"

module request_scheduler (
    input  logic                         clk_in,
    input  logic                         rst_in,
    input  logic [`SCHED_PADDR_BITS-1:0] mem_bus_addr_in,
    input  logic                         valid_in,
    input  logic                         write_in,
    input  logic [`SCHED_DATA_BITS-1:0]  val_in,
    input  logic                         cmd_ready,  // controller takes a command
    output logic [`SCHED_PADDR_BITS-1:0] addr_out,
    output logic [`SCHED_BG_BITS-1:0]    bank_group_out,
    output logic [`SCHED_BA_BITS-1:0]    bank_out,
    output logic [`SCHED_ROW_BITS-1:0]   row_out,
    output logic [`SCHED_COL_BITS-1:0]   col_out,
    output logic [`SCHED_DATA_BITS-1:0]  val_out,
    output logic [2:0]                   cmd_out,  // 0 read, 1 write, 2 act, 3 pre
    output logic                         valid_out,
    output logic                         queue_full
);

    req_if u_req_if ();
    cmd_if u_cmd_if ();

    // decode, queue the request
    request_decode u_request_decode (
        .clk_in          (clk_in),
        .rst_in          (rst_in),
        .mem_bus_addr_in (mem_bus_addr_in),
        .valid_in        (valid_in),
        .write_in        (write_in),
        .val_in          (val_in),
        .queue_full      (queue_full),
        .req             (u_req_if.source)
    );

    command_arbiter u_command_arbiter (
        .clk_in    (clk_in),
        .rst_in    (rst_in),
        .cmd_ready (cmd_ready),
        .req       (u_req_if.sink),
        .cmd       (u_cmd_if.source)
    );

    // registered command outputs
    command_encoder u_command_encoder (
        .clk_in         (clk_in),
        .rst_in         (rst_in),
        .cmd            (u_cmd_if.sink),
        .addr_out       (addr_out),
        .bank_group_out (bank_group_out),
        .bank_out       (bank_out),
        .row_out        (row_out),
        .col_out        (col_out),
        .val_out        (val_out),
        .cmd_out        (cmd_out),
        .valid_out      (valid_out)
    );

endmodule

`default_nettype wire

//--- dv/clock_gen.sv
`default_nettype none

module clock_gen (
    output logic clk_in,
    output logic rst_in
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk_in = 1'b0;
        forever #2 clk_in = ~clk_in;  // 4 ns period
    end

    // reset held over the first four rising edges
    initial begin
        rst_in = 1'b1;
        repeat (4) @(posedge clk_in);
        #1 rst_in = 1'b0;
    end

endmodule

`default_nettype wire

//--- dv/tb_request_scheduler.sv
`default_nettype none

`include "sched_defines.svh"

module tb_request_scheduler;
    timeunit 1ns;
    timeprecision 1ps;

    import sched_pkg::*;

    localparam int NUM_REQS = 200;
    localparam int TIMEOUT_CYCLES = NUM_REQS * 40;
    localparam int ROW_PAD = `SCHED_PADDR_BITS - 5 - 3 - `SCHED_ROW_BITS;
    localparam int COL_PAD = `SCHED_PADDR_BITS - 5 - 3 - `SCHED_COL_BITS;
    localparam logic [2:0] OP_RD = 3'd0;
    localparam logic [2:0] OP_WR = 3'd1;
    localparam logic [2:0] OP_ACT = 3'd2;
    localparam logic [2:0] OP_PRE = 3'd3;

    typedef struct packed {
        logic [2:0]                    cmd;
        logic [`SCHED_BG_BITS-1:0]     bank_group;
        logic [`SCHED_BA_BITS-1:0]     bank;
        logic [`SCHED_ROW_BITS-1:0]    row;
        logic [`SCHED_COL_BITS-1:0]    col;
        logic [`SCHED_PADDR_BITS-1:0]  addr;
        logic [`SCHED_DATA_BITS-1:0]   data;
    } exp_cmd_t;

    logic                         clk_in;
    logic                         rst_in;
    logic [`SCHED_PADDR_BITS-1:0] mem_bus_addr_in;
    logic                         valid_in;
    logic                         write_in;
    logic [`SCHED_DATA_BITS-1:0]  val_in;
    logic                         cmd_ready;
    logic [`SCHED_PADDR_BITS-1:0] addr_out;
    logic [`SCHED_BG_BITS-1:0]    bank_group_out;
    logic [`SCHED_BA_BITS-1:0]    bank_out;
    logic [`SCHED_ROW_BITS-1:0]   row_out;
    logic [`SCHED_COL_BITS-1:0]   col_out;
    logic [`SCHED_DATA_BITS-1:0]  val_out;
    logic [2:0]                   cmd_out;
    logic                         valid_out;
    logic                         queue_full;

    int         seed;
    int         cycle = 0;
    int         sent = 0;
    int         retired = 0;
    int         errors = 0;
    int         checks = 0;
    sched_req_t req_q[$];  // requests sent and not yet expanded
    exp_cmd_t   exp_q[$];
    logic       ref_open [`SCHED_BANKS];
    logic [`SCHED_ROW_BITS-1:0] ref_row [`SCHED_BANKS];

    clock_gen u_clock_gen (.clk_in(clk_in), .rst_in(rst_in));

    request_scheduler u_request_scheduler (.*);

    task automatic check_equal(input logic [`SCHED_DATA_BITS-1:0] actual,
                               input logic [`SCHED_DATA_BITS-1:0] expected,
                               input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("** Error @ %0t: %s is %0h, expected %0h", $time, what, actual, expected);
        end
    endtask

    function automatic logic [`SCHED_PADDR_BITS-1:0] encode_addr(input logic [2:0] cmd,
                                                                 input sched_req_t r);
        case (cmd)
            OP_ACT:  return {`SCHED_OP_ACT, r.bank_group, r.bank, {ROW_PAD{1'b0}}, r.row};
            OP_PRE:  return {`SCHED_OP_PRE, r.bank_group, r.bank, {COL_PAD{1'b0}}, r.col};
            OP_WR:   return {`SCHED_OP_WRITE, r.bank_group, r.bank, {COL_PAD{1'b0}}, r.col};
            default: return {`SCHED_OP_READ, r.bank_group, r.bank, {COL_PAD{1'b0}}, r.col};
        endcase
    endfunction

    function automatic exp_cmd_t make_cmd(input logic [2:0] cmd, input sched_req_t r);
        exp_cmd_t c;
        c.cmd        = cmd;
        c.bank_group = r.bank_group;
        c.bank       = r.bank;
        c.row        = r.row;
        c.col        = r.col;
        c.addr       = encode_addr(cmd, r);
        c.data       = (cmd == OP_WR) ? r.data : '0;
        return c;
    endfunction

    // expands one request against the reference open-row state
    function automatic void expand_request(input sched_req_t r);
        int b;
        b = {r.bank_group, r.bank};
        if (ref_open[b] && ref_row[b] != r.row) begin
            exp_q.push_back(make_cmd(OP_PRE, r));
            exp_q.push_back(make_cmd(OP_ACT, r));
        end else if (!ref_open[b]) begin
            exp_q.push_back(make_cmd(OP_ACT, r));
        end
        exp_q.push_back(make_cmd(r.write ? OP_WR : OP_RD, r));
        ref_open[b] = 1'b1;
        ref_row[b]  = r.row;
    endfunction

    task automatic send_request();
        sched_req_t r;
        logic [31:0] rnd;
        logic [3:0]  spare;
        rnd = $random(seed);
        r.write      = rnd[0];
        r.bank_group = rnd[1];
        r.bank       = rnd[3:2];
        // mostly four rows per bank for hits, now and then a far row
        r.row        = {(rnd[15:14] == 2'b00) ? rnd[21:16] : 6'd0, rnd[5:4]};
        r.col        = rnd[9:6];
        spare        = rnd[13:10];  // ignored upper address bits
        for (int i = 0; i < `SCHED_DATA_BITS / 32; i++) begin
            r.data[i*32 +: 32] = $random(seed);
        end
        mem_bus_addr_in = {spare, r.row, r.bank_group, r.bank, r.col};
        write_in        = r.write;
        val_in          = r.data;
        valid_in        = 1'b1;
        req_q.push_back(r);
        sent++;
    endtask

    initial begin : drive_stimulus
        int burst_left;
        int idle_left;
        seed            = 32'hda35f766;
        mem_bus_addr_in = '0;
        valid_in        = 1'b0;
        write_in        = 1'b0;
        val_in          = '0;
        cmd_ready       = 1'b0;
        burst_left      = 4;
        idle_left       = 0;
        for (int b = 0; b < `SCHED_BANKS; b++) begin
            ref_open[b] = 1'b0;
            ref_row[b]  = '0;
        end
        @(negedge rst_in);
        while (sent < NUM_REQS) begin
            @(posedge clk_in);
            #1;
            cmd_ready = (($random(seed) & 3) != 0);
            valid_in  = 1'b0;
            if (idle_left > 0) begin
                idle_left--;
            end else if (!queue_full && (sent - retired) < `SCHED_QUEUE_DEPTH - 1) begin
                send_request();
                burst_left--;
                if (burst_left == 0) begin
                    burst_left = 1 + ($random(seed) & 7);
                    idle_left  = $random(seed) & 3;
                end
            end
        end
        @(posedge clk_in);
        #1 valid_in = 1'b0;
        while (retired < NUM_REQS) begin
            @(posedge clk_in);
            #1 cmd_ready = (($random(seed) & 3) != 0);
        end
        repeat (10) @(posedge clk_in);
        if (exp_q.size() != 0 || req_q.size() != 0) begin
            errors++;
            $display("%0d commands and %0d requests still expected at the end of the run",
                     exp_q.size(), req_q.size());
        end
        $display("checks %0d, errors %0d, requests retired %0d of %0d",
                 checks, errors, retired, NUM_REQS);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // registered outputs checked on every falling edge
    initial begin : compare_outputs
        exp_cmd_t want;
        int       b;
        int       last_col;
        int       last_act [`SCHED_BANKS];
        int       last_pre [`SCHED_BANKS];
        last_col = -1000;
        for (int i = 0; i < `SCHED_BANKS; i++) begin
            last_act[i] = -1000;
            last_pre[i] = -1000;
        end
        @(posedge clk_in);
        forever begin
            @(negedge clk_in);
            check_equal(queue_full, 1'b0, "queue_full");
            if (!valid_out) begin
                check_equal(addr_out, {`SCHED_PADDR_BITS{1'b1}}, "idle addr_out");
            end else if (exp_q.size() == 0 && req_q.size() == 0) begin
                errors++;
                $display("command %0d came out with no request outstanding", cmd_out);
            end else begin
                if (exp_q.size() == 0) begin
                    expand_request(req_q.pop_front());
                end
                want = exp_q.pop_front();
                check_equal(cmd_out, want.cmd, "cmd_out");
                check_equal(bank_group_out, want.bank_group, "bank_group_out");
                check_equal(bank_out, want.bank, "bank_out");
                check_equal(row_out, want.row, "row_out");
                check_equal(col_out, want.col, "col_out");
                check_equal(addr_out, want.addr, "addr_out");
                check_equal(val_out, want.data, "val_out");
                b = {want.bank_group, want.bank};
                check_equal((cycle - last_act[b]) > `SCHED_ACT_LATENCY, 1'b1,
                            "command too soon after activate");
                check_equal((cycle - last_pre[b]) > `SCHED_PRE_LATENCY, 1'b1,
                            "command too soon after precharge");
                if (want.cmd == OP_ACT) begin
                    last_act[b] = cycle;
                end else if (want.cmd == OP_PRE) begin
                    last_pre[b] = cycle;
                end else begin
                    check_equal((cycle - last_col) > `SCHED_COL_GAP, 1'b1, "column gap");
                    last_col = cycle;
                    retired++;  // read or write ends the request
                end
            end
        end
    end

    initial begin : watchdog
        while (cycle < TIMEOUT_CYCLES) begin
            @(posedge clk_in);
            cycle++;
        end
        $display("timeout after %0d cycles, only %0d of %0d requests retired",
                 cycle, retired, NUM_REQS);
        $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
+incdir+design
design/sched_pkg.sv
design/sched_if.sv
design/request_decode.sv
design/bank_tracker.sv
design/command_arbiter.sv
design/command_encoder.sv
design/request_scheduler.sv
dv/clock_gen.sv
dv/tb_request_scheduler.sv

//--- Makefile
TOP = tb_request_scheduler

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
		-f src.f --top-module $(TOP) -o $(TOP)

run: build
	./obj_dir/$(TOP) | tee sim.log
	@if grep -q '^\*\* PASS \*\*$$' sim.log; then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/1ps \
		-f src.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
